// ==== all.f ====
+incdir+include
logic/dispatch_pkg.sv
logic/reg_scoreboard.sv
logic/operand_select.sv
logic/issue_allocator.sv
logic/dispatch_top.sv
bench/dispatch_tb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  make test   build the dispatch testbench with Verilator and run it"
	@echo "  make clean  remove the build directory and the log"
	@echo "  make help   show this list"

test:
	verilator --binary --timing --assert -f all.f --top-module dispatch_tb \
		-Mdir obj_dir -o dispatch_sim
	./obj_dir/dispatch_sim | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/dispatch_tb.sv ====
`include "dispatch_settings.svh"

module dispatch_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import dispatch_pkg::*;

    typedef enum logic [1:0] {OP_ALU, OP_IMM, OP_LOAD, OP_STORE} op_kind_t;

    localparam int RAND_CYCLES     = 300;
    localparam int DIRECTED_CYCLES = 45;    // Directed tests plus idle tails
    localparam int STIM_CYCLES     = 8 + DIRECTED_CYCLES + RAND_CYCLES;
    localparam disp_slot_t NO_SLOT = '0;
    localparam cdb_t       NO_BUS  = '0;

    logic       clk = 1'b0;
    logic       reset;
    disp_slot_t slot_a;
    disp_slot_t slot_b;
    cdb_t       cdb [`DISP_CDB_PORTS];
    reg_req_t   reg_req_a;
    reg_req_t   reg_req_b;
    reg_resp_t  reg_resp_a;
    reg_resp_t  reg_resp_b;
    rs_entry_t  rs_a;
    rs_entry_t  rs_b;
    rob_entry_t rob_a;
    rob_entry_t rob_b;

    word_t    rf [`DISP_PREGS];
    logic     m_ready [`DISP_PREGS];
    logic     m_buf_valid [`DISP_PREGS];
    word_t    m_buf_data [`DISP_PREGS];
    logic     m_alu_ptr;
    rob_tag_t m_rob_ptr;
    integer   seed;
    int       errors = 0;
    int       tests = 0;
    int       mark = 0;

    dispatch_top dut_i (
        .clk        (clk),
        .reset      (reset),
        .slot_a     (slot_a),
        .slot_b     (slot_b),
        .cdb        (cdb),
        .reg_req_a  (reg_req_a),
        .reg_req_b  (reg_req_b),
        .reg_resp_a (reg_resp_a),
        .reg_resp_b (reg_resp_b),
        .rs_a       (rs_a),
        .rs_b       (rs_b),
        .rob_a      (rob_a),
        .rob_b      (rob_b)
    );

    // Read-only register file
    always_comb begin
        reg_resp_a.rs1_data = rf[reg_req_a.rs1];
        reg_resp_a.rs2_data = rf[reg_req_a.rs2];
        reg_resp_b.rs1_data = rf[reg_req_b.rs1];
        reg_resp_b.rs2_data = rf[reg_req_b.rs2];
    end

    initial begin
        forever #4 clk = ~clk;
    end

    function automatic disp_slot_t make_slot(op_kind_t kind, preg_t rd, preg_t rs1, preg_t rs2);
        disp_slot_t s;
        s = '0;
        s.valid = 1'b1;
        s.pc = $random(seed);
        s.imm = $random(seed);
        s.rs1 = rs1;
        s.rs2 = rs2;
        s.ctrl.mem_read = (kind == OP_LOAD);
        s.ctrl.mem_write = (kind == OP_STORE);
        s.ctrl.alu_src = (kind != OP_ALU);
        s.ctrl.reg_write = (kind != OP_STORE);
        if (kind != OP_STORE) begin
            s.rd = rd;
            s.rd_old = preg_t'($random(seed));
        end
        return s;
    endfunction

    // Narrow range so hazards and bypasses happen often
    function automatic preg_t rand_src();
        return preg_t'($unsigned($random(seed)) % 16);
    endfunction

    function automatic disp_slot_t rand_slot();
        logic [1:0] k;
        k = 2'($random(seed));
        return make_slot(op_kind_t'(k), rand_src(), rand_src(), rand_src());
    endfunction

    function automatic cdb_t result_bus(logic valid, preg_t tag);
        cdb_t c;
        c.valid = valid;
        c.tag = tag;
        c.data = $random(seed);
        return c;
    endfunction

    function automatic operand_t ref_operand(preg_t src, disp_slot_t own, disp_slot_t older,
                                             logic is_op2);
        operand_t o;
        logic     bypassed;
        bypassed = 1'b0;
        if (src == '0) begin
            o.rdy = 1'b1;
            o.data = '0;
        end else begin
            o.rdy = m_ready[src];
            o.data = m_buf_valid[src] ? m_buf_data[src] : rf[src];
            for (int p = 0; p < `DISP_CDB_PORTS; p++) begin
                if (!bypassed && cdb[p].valid && cdb[p].tag == src) begin
                    bypassed = 1'b1;
                    o.rdy = 1'b1;
                    o.data = cdb[p].data;
                end
            end
            if (!bypassed && older.valid && !older.ctrl.mem_write && src == older.rd) begin
                o.rdy = 1'b0;   // Producer dispatched alongside
            end
        end
        if (is_op2 && own.ctrl.alu_src && !own.ctrl.mem_write) begin
            o.rdy = 1'b1;
        end
        return o;
    endfunction

    function automatic void ref_dispatch(input disp_slot_t s, input disp_slot_t older,
                                         input fu_t fu, input rob_tag_t tag,
                                         output rs_entry_t rs, output rob_entry_t rob,
                                         output reg_req_t req);
        rs = '0;
        rob = '0;
        req = '0;
        if (s.valid) begin
            req = '{rs1: s.rs1, rs2: s.rs2};
            rs = '{valid: 1'b1, fu: fu, rob_tag: tag, pc: s.pc, imm: s.imm, ctrl: s.ctrl,
                   rd: s.rd, op1: ref_operand(s.rs1, s, older, 1'b0),
                   op2: ref_operand(s.rs2, s, older, 1'b1)};
            rob = '{valid: 1'b1, pc: s.pc, rd: s.rd, rd_old: s.rd_old, rob_tag: tag,
                    ctrl: s.ctrl};
        end
    endfunction

    task automatic reset_model();
        for (int r = 0; r < `DISP_PREGS; r++) begin
            m_ready[r] = 1'b1;
            m_buf_valid[r] = 1'b0;
        end
        m_alu_ptr = 1'b0;
        m_rob_ptr = '0;
    endtask

    // State after the coming edge
    task automatic update_model();
        if (slot_a.valid && !slot_a.ctrl.mem_write) begin
            m_ready[slot_a.rd] = 1'b0;
            m_buf_valid[slot_a.rd] = 1'b0;
        end
        if (slot_b.valid && !slot_b.ctrl.mem_write) begin
            m_ready[slot_b.rd] = 1'b0;
            m_buf_valid[slot_b.rd] = 1'b0;
        end
        for (int p = 0; p < `DISP_CDB_PORTS; p++) begin
            if (cdb[p].valid) begin
                m_ready[cdb[p].tag] = 1'b1;
                m_buf_valid[cdb[p].tag] = 1'b1;
                m_buf_data[cdb[p].tag] = cdb[p].data;
            end
        end
        m_ready[0] = 1'b1;
        m_alu_ptr = m_alu_ptr ^ (slot_a.valid && !slot_a.ctrl.mem_read)
                              ^ (slot_b.valid && !slot_b.ctrl.mem_read);
        m_rob_ptr = m_rob_ptr + rob_tag_t'(slot_a.valid) + rob_tag_t'(slot_b.valid);
    endtask

    task automatic check_rs(string name, rs_entry_t got, rs_entry_t exp);
        string field;
        if (got !== exp) begin
            field = (got.op1 !== exp.op1) ? "op1" : (got.op2 !== exp.op2) ? "op2" : "control";
            errors++;
            $display("Mismatch at %0t ns: %s.%s got %h expected %h", $time, name, field, got, exp);
        end
    endtask

    task automatic check_rob(string name, rob_entry_t got, rob_entry_t exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_req(string name, reg_req_t got, reg_req_t exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    always @(negedge clk) begin : compare
        rs_entry_t  exp_rs;
        rob_entry_t exp_rob;
        reg_req_t   exp_req;
        fu_t        fu_a;
        fu_t        fu_b;
        logic       alu_b_sel;
        rob_tag_t   tag_b;
        if (reset) begin
            reset_model();
        end else begin
            fu_a = slot_a.ctrl.mem_read ? FU_MEM : (m_alu_ptr ? FU_ALU1 : FU_ALU0);
            alu_b_sel = m_alu_ptr ^ (slot_a.valid && !slot_a.ctrl.mem_read);
            fu_b = slot_b.ctrl.mem_read ? FU_MEM : (alu_b_sel ? FU_ALU1 : FU_ALU0);
            tag_b = m_rob_ptr + rob_tag_t'(slot_a.valid);
            ref_dispatch(slot_a, NO_SLOT, fu_a, m_rob_ptr, exp_rs, exp_rob, exp_req);
            check_rs("rs_a", rs_a, exp_rs);
            check_rob("rob_a", rob_a, exp_rob);
            check_req("reg_req_a", reg_req_a, exp_req);
            ref_dispatch(slot_b, slot_a, fu_b, tag_b, exp_rs, exp_rob, exp_req);
            check_rs("rs_b", rs_b, exp_rs);
            check_rob("rob_b", rob_b, exp_rob);
            check_req("reg_req_b", reg_req_b, exp_req);
            update_model();
        end
    end

    task automatic drive(disp_slot_t a, disp_slot_t b, cdb_t c0, cdb_t c1);
        @(posedge clk);
        slot_a <= a;
        slot_b <= b;
        cdb[0] <= c0;
        cdb[1] <= c1;
    endtask

    task automatic end_test(string name);
        drive(NO_SLOT, NO_SLOT, NO_BUS, NO_BUS);
        @(posedge clk);
        tests++;
        $display("%-16s %s (%0d errors)", name, (errors == mark) ? "ok" : "failed", errors - mark);
        mark = errors;
    endtask

    initial begin : stimulus
        disp_slot_t a;
        disp_slot_t b;
        preg_t      t0;
        preg_t      t1;
        seed = 32'ha154;
        for (int i = 0; i < `DISP_PREGS; i++) begin
            rf[i] = $random(seed) ^ (i << 24);
        end
        reset = 1'b1;
        slot_a = '0;
        slot_b = '0;
        cdb[0] = '0;
        cdb[1] = '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        // Stores keep every register at its reset readiness
        repeat (8) begin
            drive(make_slot(OP_STORE, '0, preg_t'($random(seed)), preg_t'($random(seed))),
                  make_slot(OP_STORE, '0, preg_t'($random(seed)), '0), NO_BUS, NO_BUS);
        end
        end_test("reset_state");

        drive(make_slot(OP_ALU, 6'd5, 6'd1, 6'd2), NO_SLOT, NO_BUS, NO_BUS);
        drive(make_slot(OP_STORE, '0, 6'd5, 6'd3), NO_SLOT, NO_BUS, NO_BUS);
        drive(make_slot(OP_STORE, '0, 6'd5, 6'd5), make_slot(OP_ALU, 6'd6, 6'd5, 6'd0),
              NO_BUS, NO_BUS);
        drive(make_slot(OP_ALU, 6'd7, 6'd6, 6'd5), NO_SLOT, NO_BUS, NO_BUS);
        end_test("readiness");

        drive(make_slot(OP_ALU, 6'd7, 6'd5, 6'd6), NO_SLOT,
              result_bus(1'b1, 6'd5), result_bus(1'b1, 6'd6));
        drive(make_slot(OP_ALU, 6'd8, 6'd5, 6'd6), NO_SLOT, NO_BUS, NO_BUS);
        drive(make_slot(OP_ALU, 6'd5, 6'd6, 6'd7), NO_SLOT, NO_BUS, result_bus(1'b1, 6'd7));
        drive(make_slot(OP_STORE, '0, 6'd5, 6'd7), NO_SLOT, NO_BUS, NO_BUS);
        drive(make_slot(OP_ALU, 6'd9, 6'd0, 6'd0), NO_SLOT, result_bus(1'b1, 6'd9), NO_BUS);
        drive(make_slot(OP_STORE, '0, 6'd9, 6'd9), NO_SLOT, NO_BUS, NO_BUS);
        end_test("bypass_buffer");

        drive(make_slot(OP_ALU, 6'd10, 6'd1, 6'd2), make_slot(OP_IMM, 6'd11, 6'd10, 6'd10),
              NO_BUS, NO_BUS);
        drive(make_slot(OP_ALU, 6'd12, 6'd3, 6'd4), make_slot(OP_ALU, 6'd13, 6'd12, 6'd12),
              result_bus(1'b1, 6'd12), NO_BUS);
        drive(make_slot(OP_STORE, '0, 6'd1, 6'd2), make_slot(OP_ALU, 6'd14, 6'd0, 6'd13),
              NO_BUS, NO_BUS);
        end_test("slot_b_hazard");

        drive(make_slot(OP_LOAD, 6'd20, 6'd1, 6'd0), NO_SLOT, NO_BUS, NO_BUS);
        drive(make_slot(OP_ALU, 6'd21, 6'd1, 6'd2), NO_SLOT, NO_BUS, NO_BUS);
        drive(make_slot(OP_ALU, 6'd22, 6'd1, 6'd2), make_slot(OP_IMM, 6'd23, 6'd3, 6'd0),
              NO_BUS, NO_BUS);
        drive(make_slot(OP_LOAD, 6'd24, 6'd1, 6'd0), make_slot(OP_ALU, 6'd25, 6'd2, 6'd3),
              NO_BUS, NO_BUS);
        drive(make_slot(OP_ALU, 6'd26, 6'd1, 6'd2), make_slot(OP_LOAD, 6'd27, 6'd4, 6'd0),
              NO_BUS, NO_BUS);
        drive(make_slot(OP_IMM, 6'd28, 6'd1, 6'd0), NO_SLOT, NO_BUS, NO_BUS);
        drive(make_slot(OP_LOAD, 6'd29, 6'd1, 6'd0), make_slot(OP_LOAD, 6'd30, 6'd2, 6'd0),
              NO_BUS, NO_BUS);
        drive(make_slot(OP_STORE, '0, 6'd1, 6'd2), make_slot(OP_ALU, 6'd31, 6'd1, 6'd2),
              NO_BUS, NO_BUS);
        end_test("fu_assign");

        for (int n = 0; n < RAND_CYCLES; n++) begin
            a = rand_slot();
            b = rand_slot();
            if ($unsigned($random(seed)) % 8 == 0) begin
                a.valid = 1'b0;     // Garbage fields must not leak out
            end
            if (!a.valid || $unsigned($random(seed)) % 2 == 0) begin
                b.valid = 1'b0;
            end
            t0 = rand_src();
            t1 = t0 ^ preg_t'(1 + $unsigned($random(seed)) % 15);
            drive(a, b, result_bus(1'($random(seed)), t0), result_bus(1'($random(seed)), t1));
        end
        end_test("random_stream");

        $display("%0d tests, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin : watchdog
        #(STIM_CYCLES * 8 * 2);
        $display("Watchdog timeout: the tests did not finish in time");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== logic/dispatch_top.sv ====
`include "dispatch_settings.svh"

module dispatch_top (
    input  logic                     clk,
    input  logic                     reset,
    input  dispatch_pkg::disp_slot_t slot_a,
    input  dispatch_pkg::disp_slot_t slot_b,
    input  dispatch_pkg::cdb_t       cdb [`DISP_CDB_PORTS],
    output dispatch_pkg::reg_req_t   reg_req_a,     // To register file
    output dispatch_pkg::reg_req_t   reg_req_b,
    input  dispatch_pkg::reg_resp_t  reg_resp_a,    // Same-cycle response
    input  dispatch_pkg::reg_resp_t  reg_resp_b,
    output dispatch_pkg::rs_entry_t  rs_a,
    output dispatch_pkg::rs_entry_t  rs_b,
    output dispatch_pkg::rob_entry_t rob_a,
    output dispatch_pkg::rob_entry_t rob_b
);
    import dispatch_pkg::*;

    preg_t      src_addr [4];
    src_state_t src_state [4];
    fu_t        fu_a;
    fu_t        fu_b;
    rob_tag_t   tag_a;
    rob_tag_t   tag_b;

    reg_scoreboard scoreboard_i (
        .clk       (clk),
        .reset     (reset),
        .slot_a    (slot_a),
        .slot_b    (slot_b),
        .cdb       (cdb),
        .src_addr  (src_addr),
        .src_state (src_state)
    );

    operand_select operand_i (
        .slot_a     (slot_a),
        .slot_b     (slot_b),
        .cdb        (cdb),
        .reg_req_a  (reg_req_a),
        .reg_req_b  (reg_req_b),
        .reg_resp_a (reg_resp_a),
        .reg_resp_b (reg_resp_b),
        .src_addr   (src_addr),
        .src_state  (src_state),
        .fu_a       (fu_a),
        .fu_b       (fu_b),
        .tag_a      (tag_a),
        .tag_b      (tag_b),
        .rs_a       (rs_a),
        .rs_b       (rs_b)
    );

    issue_allocator alloc_i (
        .clk    (clk),
        .reset  (reset),
        .slot_a (slot_a),
        .slot_b (slot_b),
        .fu_a   (fu_a),
        .fu_b   (fu_b),
        .tag_a  (tag_a),
        .tag_b  (tag_b),
        .rob_a  (rob_a),
        .rob_b  (rob_b)
    );

endmodule

// ==== logic/issue_allocator.sv ====
module issue_allocator (
    input  logic                     clk,
    input  logic                     reset,
    input  dispatch_pkg::disp_slot_t slot_a,
    input  dispatch_pkg::disp_slot_t slot_b,
    output dispatch_pkg::fu_t        fu_a,
    output dispatch_pkg::fu_t        fu_b,
    output dispatch_pkg::rob_tag_t   tag_a,
    output dispatch_pkg::rob_tag_t   tag_b,
    output dispatch_pkg::rob_entry_t rob_a,
    output dispatch_pkg::rob_entry_t rob_b
);
    import dispatch_pkg::*;

    logic     alu_ptr;      // Next ALU to hand out
    rob_tag_t rob_ptr;
    logic     alu_a;
    logic     alu_b;
    logic [1:0] n_valid;

    function automatic fu_t alu_fu(logic sel);
        return sel ? FU_ALU1 : FU_ALU0;
    endfunction

    function automatic rob_entry_t make_rob(disp_slot_t s, rob_tag_t tag);
        rob_entry_t e;
        e = '0;
        if (s.valid) begin
            e.valid   = 1'b1;
            e.pc      = s.pc;
            e.rd      = s.rd;
            e.rd_old  = s.rd_old;
            e.rob_tag = tag;
            e.ctrl    = s.ctrl;
        end
        return e;
    endfunction

    assign alu_a   = slot_a.valid && !slot_a.ctrl.mem_read;
    assign alu_b   = slot_b.valid && !slot_b.ctrl.mem_read;
    assign n_valid = {1'b0, slot_a.valid} + {1'b0, slot_b.valid};

    always_comb begin
        fu_a = FU_ALU0;
        fu_b = FU_ALU0;
        if (slot_a.valid) begin
            fu_a = slot_a.ctrl.mem_read ? FU_MEM : alu_fu(alu_ptr);
        end
        if (slot_b.valid) begin
            fu_b = slot_b.ctrl.mem_read ? FU_MEM : alu_fu(alu_ptr ^ alu_a);  // Other ALU if a took one
        end
    end

    assign tag_a = rob_ptr;
    assign tag_b = rob_ptr + rob_tag_t'(slot_a.valid);

    always_ff @(posedge clk) begin
        if (reset) begin
            alu_ptr <= 1'b0;
            rob_ptr <= '0;
        end else begin
            alu_ptr <= alu_ptr ^ alu_a ^ alu_b;
            rob_ptr <= rob_ptr + rob_tag_t'(n_valid);   // Wraps with the ROB
        end
    end

    assign rob_a = make_rob(slot_a, tag_a);
    assign rob_b = make_rob(slot_b, tag_b);

    b_needs_a: assert property (@(posedge clk) disable iff (reset)
        slot_b.valid |-> slot_a.valid);

endmodule

// ==== logic/operand_select.sv ====
`include "dispatch_settings.svh"

module operand_select (
    input  dispatch_pkg::disp_slot_t slot_a,
    input  dispatch_pkg::disp_slot_t slot_b,
    input  dispatch_pkg::cdb_t       cdb [`DISP_CDB_PORTS],
    output dispatch_pkg::reg_req_t   reg_req_a,
    output dispatch_pkg::reg_req_t   reg_req_b,
    input  dispatch_pkg::reg_resp_t  reg_resp_a,
    input  dispatch_pkg::reg_resp_t  reg_resp_b,
    output dispatch_pkg::preg_t      src_addr [4],
    input  dispatch_pkg::src_state_t src_state [4],
    input  dispatch_pkg::fu_t        fu_a,
    input  dispatch_pkg::fu_t        fu_b,
    input  dispatch_pkg::rob_tag_t   tag_a,
    input  dispatch_pkg::rob_tag_t   tag_b,
    output dispatch_pkg::rs_entry_t  rs_a,
    output dispatch_pkg::rs_entry_t  rs_b
);
    import dispatch_pkg::*;

    word_t    rf_data [4];
    operand_t opnd [4];
    logic [3:0] byp_hit;
    logic       a_writes;

    function automatic reg_req_t make_req(disp_slot_t s);
        reg_req_t r;
        r = '0;
        if (s.valid) begin
            r.rs1 = s.rs1;
            r.rs2 = s.rs2;
        end
        return r;
    endfunction

    function automatic rs_entry_t make_rs(disp_slot_t s, fu_t fu, rob_tag_t tag,
                                          operand_t op1, operand_t op2);
        rs_entry_t e;
        e = '0;
        if (s.valid) begin
            e.valid   = 1'b1;
            e.fu      = fu;
            e.rob_tag = tag;
            e.pc      = s.pc;
            e.imm     = s.imm;
            e.ctrl    = s.ctrl;
            e.rd      = s.rd;
            e.op1     = op1;
            e.op2     = op2;
        end
        return e;
    endfunction

    assign reg_req_a = make_req(slot_a);
    assign reg_req_b = make_req(slot_b);

    // Source order a.rs1, a.rs2, b.rs1, b.rs2
    assign src_addr[0] = reg_req_a.rs1;
    assign src_addr[1] = reg_req_a.rs2;
    assign src_addr[2] = reg_req_b.rs1;
    assign src_addr[3] = reg_req_b.rs2;

    assign rf_data[0] = reg_resp_a.rs1_data;
    assign rf_data[1] = reg_resp_a.rs2_data;
    assign rf_data[2] = reg_resp_b.rs1_data;
    assign rf_data[3] = reg_resp_b.rs2_data;

    assign a_writes = slot_a.valid && !slot_a.ctrl.mem_write;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            byp_hit[i]   = 1'b0;
            opnd[i].rdy  = src_state[i].rdy;
            opnd[i].data = src_state[i].buf_valid ? src_state[i].buf_data : rf_data[i];
            for (int p = `DISP_CDB_PORTS - 1; p >= 0; p--) begin  // Lowest port lands last
                if (cdb[p].valid && cdb[p].tag == src_addr[i]) begin
                    byp_hit[i]   = 1'b1;
                    opnd[i].rdy  = 1'b1;
                    opnd[i].data = cdb[p].data;
                end
            end
            if (src_addr[i] == '0) begin
                opnd[i].rdy  = 1'b1;
                opnd[i].data = '0;
            end
        end

        // Slot b waits on the producer in slot a
        for (int i = 2; i < 4; i++) begin
            if (a_writes && src_addr[i] != '0 && src_addr[i] == slot_a.rd && !byp_hit[i]) begin
                opnd[i].rdy = 1'b0;
            end
        end

        if (slot_a.ctrl.alu_src && !slot_a.ctrl.mem_write) begin
            opnd[1].rdy = 1'b1;     // Immediate operand
        end
        if (slot_b.ctrl.alu_src && !slot_b.ctrl.mem_write) begin
            opnd[3].rdy = 1'b1;
        end
    end

    assign rs_a = make_rs(slot_a, fu_a, tag_a, opnd[0], opnd[1]);
    assign rs_b = make_rs(slot_b, fu_b, tag_b, opnd[2], opnd[3]);

endmodule

// ==== logic/reg_scoreboard.sv ====
`include "dispatch_settings.svh"

module reg_scoreboard (
    input  logic                     clk,
    input  logic                     reset,
    input  dispatch_pkg::disp_slot_t slot_a,
    input  dispatch_pkg::disp_slot_t slot_b,
    input  dispatch_pkg::cdb_t       cdb [`DISP_CDB_PORTS],
    input  dispatch_pkg::preg_t      src_addr [4],
    output dispatch_pkg::src_state_t src_state [4]
);
    import dispatch_pkg::*;

    logic [`DISP_PREGS-1:0] ready;
    logic [`DISP_PREGS-1:0] buf_valid;
    word_t                  buf_data [`DISP_PREGS];
    logic                   cdb_dup;

    // Later assignments win, so result buses override a same-cycle dispatch
    always_ff @(posedge clk) begin
        if (reset) begin
            ready     <= '1;
            buf_valid <= '0;
        end else begin
            if (slot_a.valid && !slot_a.ctrl.mem_write) begin
                ready[slot_a.rd]     <= 1'b0;
                buf_valid[slot_a.rd] <= 1'b0;   // Old value is stale after reallocation
            end
            if (slot_b.valid && !slot_b.ctrl.mem_write) begin
                ready[slot_b.rd]     <= 1'b0;
                buf_valid[slot_b.rd] <= 1'b0;
            end
            for (int p = 0; p < `DISP_CDB_PORTS; p++) begin
                if (cdb[p].valid) begin
                    ready[cdb[p].tag]     <= 1'b1;
                    buf_valid[cdb[p].tag] <= 1'b1;
                end
            end
            ready[0] <= 1'b1;                   // x0 never waits
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < `DISP_CDB_PORTS; p++) begin
            if (cdb[p].valid) begin
                buf_data[cdb[p].tag] <= cdb[p].data;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            src_state[i].rdy       = ready[src_addr[i]];
            src_state[i].buf_valid = buf_valid[src_addr[i]];
            src_state[i].buf_data  = buf_data[src_addr[i]];
        end
    end

    // Two buses writing one register in a cycle
    always_comb begin
        cdb_dup = 1'b0;
        for (int p = 0; p < `DISP_CDB_PORTS; p++) begin
            for (int q = p + 1; q < `DISP_CDB_PORTS; q++) begin
                if (cdb[p].valid && cdb[q].valid && cdb[p].tag == cdb[q].tag) begin
                    cdb_dup = 1'b1;
                end
            end
        end
    end

    a_store_rd_zero: assert property (@(posedge clk) disable iff (reset)
        slot_a.valid && slot_a.ctrl.mem_write |-> slot_a.rd == '0 && slot_a.rd_old == '0);

    b_store_rd_zero: assert property (@(posedge clk) disable iff (reset)
        slot_b.valid && slot_b.ctrl.mem_write |-> slot_b.rd == '0 && slot_b.rd_old == '0);

    cdb_unique_tag: assert property (@(posedge clk) disable iff (reset) !cdb_dup);

endmodule

// ==== logic/dispatch_pkg.sv ====
`include "dispatch_settings.svh"

package dispatch_pkg;

    typedef logic [`DISP_XLEN-1:0]              word_t;
    typedef logic [$clog2(`DISP_PREGS)-1:0]     preg_t;
    typedef logic [$clog2(`DISP_ROB_DEPTH)-1:0] rob_tag_t;

    typedef enum logic [1:0] {
        FU_ALU0 = 2'd0,
        FU_ALU1 = 2'd1,
        FU_MEM  = 2'd2
    } fu_t;

    typedef struct packed {
        logic mem_read;
        logic mem_write;
        logic alu_src;      // Op2 comes from imm
        logic reg_write;
    } ctrl_t;

    // One renamed instruction
    typedef struct packed {
        logic  valid;
        word_t pc;
        preg_t rd;
        preg_t rd_old;      // Freed at commit
        preg_t rs1;
        preg_t rs2;
        word_t imm;
        ctrl_t ctrl;
    } disp_slot_t;

    typedef struct packed {
        logic  valid;
        preg_t tag;
        word_t data;
    } cdb_t;

    typedef struct packed {
        logic  rdy;
        logic  buf_valid;
        word_t buf_data;
    } src_state_t;

    typedef struct packed {
        logic  rdy;
        word_t data;
    } operand_t;

    typedef struct packed {
        preg_t rs1;
        preg_t rs2;
    } reg_req_t;

    typedef struct packed {
        word_t rs1_data;
        word_t rs2_data;
    } reg_resp_t;

    typedef struct packed {
        logic     valid;
        fu_t      fu;
        rob_tag_t rob_tag;
        word_t    pc;
        word_t    imm;
        ctrl_t    ctrl;
        preg_t    rd;
        operand_t op1;
        operand_t op2;
    } rs_entry_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        preg_t    rd;
        preg_t    rd_old;
        rob_tag_t rob_tag;
        ctrl_t    ctrl;
    } rob_entry_t;

endpackage

// ==== include/dispatch_settings.svh ====
`ifndef DISPATCH_SETTINGS_SVH
`define DISPATCH_SETTINGS_SVH

// Physical register file size
`define DISP_PREGS      64

// Reorder buffer slots where tags wrap
`define DISP_ROB_DEPTH  16

// Data word width
`define DISP_XLEN       32

// Result buses broadcast by the execution units
`define DISP_CDB_PORTS  2

`endif
